// File: src/core_settings.svh
/* core width and reset settings */

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address width
`define XLEN 64

`define INST_WIDTH 32

// integer register file
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// first fetch address after reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

// File: src/core_pkg.sv
/* core shared types */

`include "core_settings.svh"

package core_pkg;

  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [`INST_WIDTH-1:0] inst_t;
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE
  } branch_kind_t;

  typedef enum logic {
    WB_ALU,
    WB_LOAD
  } wb_src_t;

endpackage

// File: src/fetch_stage.sv
/* fetch stage */

`timescale 1ns/100ps

`include "core_settings.svh"

module fetch_stage import core_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  stall,
  input  logic  branch_taken,
  input  xlen_t branch_target,
  output xlen_t inst_addr,
  output xlen_t id_pc,
  output logic  id_valid
);

  // pc of the instruction currently in decode
  xlen_t pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc       <= `RESET_PC;
      id_valid <= 1'b0;
    end else if (branch_taken) begin
      pc       <= branch_target;
      id_valid <= 1'b0;
    end else if (!stall) begin
      // hold while empty so the fetched word gets decoded next cycle
      if (id_valid) begin
        pc <= pc + xlen_t'(4);
      end
      id_valid <= 1'b1;
    end
  end

  assign inst_addr = pc;
  assign id_pc     = pc;

endmodule

// File: src/decode_stage.sv
/* instruction decode and id/ex register */

`timescale 1ns/100ps

`include "core_settings.svh"

module decode_stage import core_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  inst_t        inst,
  input  xlen_t        id_pc,
  input  logic         id_valid,
  input  logic         stall,
  input  logic         branch_taken,
  input  xlen_t        rs1_data,
  input  xlen_t        rs2_data,
  output reg_addr_t    rs1_addr,
  output reg_addr_t    rs2_addr,
  output logic         id_uses_rs1,
  output logic         id_uses_rs2,
  output logic         ex_valid,
  output xlen_t        ex_pc,
  output xlen_t        ex_imm,
  output alu_op_t      ex_alu_op,
  output branch_kind_t ex_branch,
  output logic         ex_use_imm,
  output reg_addr_t    ex_rs1_addr,
  output reg_addr_t    ex_rs2_addr,
  output xlen_t        ex_rs1_data,
  output xlen_t        ex_rs2_data,
  output reg_addr_t    ex_rd_addr,
  output logic         ex_rd_wr_ena,
  output logic         ex_mem_rd,
  output logic         ex_mem_wr,
  output wb_src_t      ex_wb_src
);

  logic [2:0]   funct3;
  logic [6:0]   funct7;
  reg_addr_t    rd_addr;
  xlen_t        imm_i;
  xlen_t        imm_s;
  xlen_t        imm_b;
  xlen_t        dec_imm;
  alu_op_t      dec_alu_op;
  branch_kind_t dec_branch;
  wb_src_t      dec_wb_src;
  logic         dec_use_imm;
  logic         dec_rd_wr;
  logic         dec_mem_rd;
  logic         dec_mem_wr;
  logic         dec_uses_rs1;
  logic         dec_uses_rs2;

  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign rd_addr  = inst[11:7];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  // sign-extended immediates
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  always_comb begin
    dec_imm      = imm_i;
    dec_alu_op   = ALU_ADD;
    dec_branch   = BR_NONE;
    dec_wb_src   = WB_ALU;
    dec_use_imm  = 1'b0;
    dec_rd_wr    = 1'b0;
    dec_mem_rd   = 1'b0;
    dec_mem_wr   = 1'b0;
    dec_uses_rs1 = 1'b0;
    dec_uses_rs2 = 1'b0;
    case (opcode_t'(inst[6:0]))
      OP: begin
        dec_rd_wr    = 1'b1;
        dec_uses_rs1 = 1'b1;
        dec_uses_rs2 = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec_alu_op = ALU_ADD;
          10'b0100000_000: dec_alu_op = ALU_SUB;
          10'b0000000_111: dec_alu_op = ALU_AND;
          10'b0000000_110: dec_alu_op = ALU_OR;
          10'b0000000_100: dec_alu_op = ALU_XOR;
          default:         dec_rd_wr  = 1'b0;
        endcase
      end
      OP_IMM: if (funct3 == 3'b000) begin
        dec_rd_wr    = 1'b1;
        dec_use_imm  = 1'b1;
        dec_uses_rs1 = 1'b1;
      end
      LOAD: if (funct3 == 3'b011) begin
        dec_rd_wr    = 1'b1;
        dec_mem_rd   = 1'b1;
        dec_use_imm  = 1'b1;
        dec_uses_rs1 = 1'b1;
        dec_wb_src   = WB_LOAD;
      end
      STORE: if (funct3 == 3'b011) begin
        dec_imm      = imm_s;
        dec_mem_wr   = 1'b1;
        dec_use_imm  = 1'b1;
        dec_uses_rs1 = 1'b1;
        dec_uses_rs2 = 1'b1;
      end
      BRANCH: if (funct3[2:1] == 2'b00) begin
        dec_imm      = imm_b;
        dec_branch   = funct3[0] ? BR_NE : BR_EQ;
        dec_uses_rs1 = 1'b1;
        dec_uses_rs2 = 1'b1;
      end
      default: begin
        // anything else passes through as a no-op
        dec_rd_wr = 1'b0;
      end
    endcase
  end

  assign id_uses_rs1 = dec_uses_rs1 & id_valid;
  assign id_uses_rs2 = dec_uses_rs2 & id_valid;

  // stall and flush both insert a bubble
  always_ff @(posedge clock) begin
    if (reset || stall || branch_taken || !id_valid) begin
      ex_valid     <= 1'b0;
      ex_rd_wr_ena <= 1'b0;
      ex_mem_rd    <= 1'b0;
      ex_mem_wr    <= 1'b0;
      ex_branch    <= BR_NONE;
    end else begin
      ex_valid     <= 1'b1;
      ex_rd_wr_ena <= dec_rd_wr && (rd_addr != '0);
      ex_mem_rd    <= dec_mem_rd;
      ex_mem_wr    <= dec_mem_wr;
      ex_branch    <= dec_branch;
    end
  end

  always_ff @(posedge clock) begin
    ex_pc       <= id_pc;
    ex_imm      <= dec_imm;
    ex_alu_op   <= dec_alu_op;
    ex_use_imm  <= dec_use_imm;
    ex_wb_src   <= dec_wb_src;
    ex_rd_addr  <= rd_addr;
    ex_rs1_addr <= rs1_addr;
    ex_rs2_addr <= rs2_addr;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
  end

endmodule

// File: src/regfile.sv
/* integer register file */

`timescale 1ns/100ps

`include "core_settings.svh"

module regfile import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t wr_addr,
  input  xlen_t     wr_data,
  input  logic      wr_ena,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data
);

  xlen_t regs [`REG_COUNT];

  // write-first read with x0 tied to zero
  function automatic xlen_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_ena && (wr_addr == addr)) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

// File: src/hazard_unit.sv
/* load-use stall and ex forwarding */

`timescale 1ns/100ps

module hazard_unit import core_pkg::*; (
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  logic      id_uses_rs1,
  input  logic      id_uses_rs2,
  input  logic      ex_mem_rd,
  input  reg_addr_t ex_rd_addr,
  input  logic      ex_valid,
  input  reg_addr_t ex_rs1_addr,
  input  reg_addr_t ex_rs2_addr,
  input  xlen_t     ex_rs1_data,
  input  xlen_t     ex_rs2_data,
  input  reg_addr_t mem_rd_addr,
  input  logic      mem_rd_wr_ena,
  input  xlen_t     mem_alu_result,
  input  reg_addr_t wb_rd_addr,
  input  logic      wb_rd_wr_ena,
  input  xlen_t     wb_data,
  output logic      stall,
  output xlen_t     rs1_value,
  output xlen_t     rs2_value
);

  logic load_in_ex;

  // youngest producer wins
  function automatic xlen_t forward(input reg_addr_t addr, input xlen_t reg_value);
    if (addr == '0) begin
      return reg_value;
    end
    if (mem_rd_wr_ena && (mem_rd_addr == addr)) begin
      return mem_alu_result;
    end
    if (wb_rd_wr_ena && (wb_rd_addr == addr)) begin
      return wb_data;
    end
    return reg_value;
  endfunction

  always_comb begin
    rs1_value = forward(ex_rs1_addr, ex_rs1_data);
    rs2_value = forward(ex_rs2_addr, ex_rs2_data);
  end

  // load data only exists from wb on, so hold the consumer one cycle
  assign load_in_ex = ex_valid && ex_mem_rd && (ex_rd_addr != '0);
  assign stall = load_in_ex && ((id_uses_rs1 && (rs1_addr == ex_rd_addr)) ||
                                (id_uses_rs2 && (rs2_addr == ex_rd_addr)));

endmodule

// File: src/execute_stage.sv
/* alu, branch resolve and ex/mem register */

`timescale 1ns/100ps

module execute_stage import core_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         ex_valid,
  input  xlen_t        ex_pc,
  input  xlen_t        ex_imm,
  input  alu_op_t      ex_alu_op,
  input  branch_kind_t ex_branch,
  input  logic         ex_use_imm,
  input  reg_addr_t    ex_rd_addr,
  input  logic         ex_rd_wr_ena,
  input  logic         ex_mem_rd,
  input  logic         ex_mem_wr,
  input  wb_src_t      ex_wb_src,
  input  xlen_t        rs1_value,
  input  xlen_t        rs2_value,
  output logic         branch_taken,
  output xlen_t        branch_target,
  output logic         mem_valid,
  output xlen_t        mem_pc,
  output xlen_t        mem_alu_result,
  output xlen_t        mem_store_data,
  output reg_addr_t    mem_rd_addr,
  output logic         mem_rd_wr_ena,
  output logic         mem_mem_rd,
  output logic         mem_mem_wr,
  output wb_src_t      mem_wb_src
);

  xlen_t operand_b;
  xlen_t alu_result;
  logic  operands_equal;
  logic  branch_cond;

  assign operand_b = ex_use_imm ? ex_imm : rs2_value;

  always_comb begin
    case (ex_alu_op)
      ALU_SUB: alu_result = rs1_value - operand_b;
      ALU_AND: alu_result = rs1_value & operand_b;
      ALU_OR:  alu_result = rs1_value | operand_b;
      ALU_XOR: alu_result = rs1_value ^ operand_b;
      default: alu_result = rs1_value + operand_b;
    endcase
  end

  // branches compare the two register operands
  assign operands_equal = (rs1_value == rs2_value);

  always_comb begin
    case (ex_branch)
      BR_EQ:   branch_cond = operands_equal;
      BR_NE:   branch_cond = !operands_equal;
      default: branch_cond = 1'b0;
    endcase
  end

  assign branch_taken  = ex_valid && branch_cond;
  assign branch_target = ex_pc + ex_imm;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid     <= 1'b0;
      mem_rd_wr_ena <= 1'b0;
      mem_mem_rd    <= 1'b0;
      mem_mem_wr    <= 1'b0;
    end else begin
      mem_valid     <= ex_valid;
      mem_rd_wr_ena <= ex_valid && ex_rd_wr_ena;
      mem_mem_rd    <= ex_valid && ex_mem_rd;
      mem_mem_wr    <= ex_valid && ex_mem_wr;
    end
  end

  always_ff @(posedge clock) begin
    mem_pc         <= ex_pc;
    mem_alu_result <= alu_result;
    mem_store_data <= rs2_value;
    mem_rd_addr    <= ex_rd_addr;
    mem_wb_src     <= ex_wb_src;
  end

endmodule

// File: src/memory_stage.sv
/* data access and mem/wb register */

`timescale 1ns/100ps

module memory_stage import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      mem_valid,
  input  xlen_t     mem_pc,
  input  xlen_t     mem_alu_result,
  input  xlen_t     mem_store_data,
  input  reg_addr_t mem_rd_addr,
  input  logic      mem_rd_wr_ena,
  input  logic      mem_mem_rd,
  input  logic      mem_mem_wr,
  input  wb_src_t   mem_wb_src,
  input  xlen_t     data_rd_data,
  output xlen_t     data_addr,
  output xlen_t     data_wr_data,
  output logic      data_wr_ena,
  output logic      data_rd_ena,
  output reg_addr_t wb_rd_addr,
  output logic      wb_rd_wr_ena,
  output xlen_t     wb_data,
  output logic      commit_valid,
  output xlen_t     commit_pc,
  output logic      commit_reg_wr_ena,
  output reg_addr_t commit_reg_addr,
  output xlen_t     commit_reg_data
);

  assign data_addr    = mem_alu_result;
  assign data_wr_data = mem_store_data;
  assign data_wr_ena  = mem_valid && mem_mem_wr;
  assign data_rd_ena  = mem_valid && mem_mem_rd;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      wb_rd_wr_ena <= 1'b0;
    end else begin
      commit_valid <= mem_valid;
      wb_rd_wr_ena <= mem_valid && mem_rd_wr_ena;
    end
  end

  always_ff @(posedge clock) begin
    commit_pc  <= mem_pc;
    wb_rd_addr <= mem_rd_addr;
    wb_data    <= (mem_wb_src == WB_LOAD) ? data_rd_data : mem_alu_result;
  end

  // the commit record is the wb register itself
  assign commit_reg_wr_ena = wb_rd_wr_ena;
  assign commit_reg_addr   = wb_rd_addr;
  assign commit_reg_data   = wb_data;

endmodule

// File: src/core_top.sv
/* five-stage rv64 integer core */

`timescale 1ns/100ps

module core_top import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  output xlen_t     inst_addr,
  input  inst_t     inst,
  output xlen_t     data_addr,
  output xlen_t     data_wr_data,
  output logic      data_wr_ena,
  output logic      data_rd_ena,
  input  xlen_t     data_rd_data,
  output logic      commit_valid,
  output xlen_t     commit_pc,
  output logic      commit_reg_wr_ena,
  output reg_addr_t commit_reg_addr,
  output xlen_t     commit_reg_data
);

  // if/id and hazard control
  xlen_t        id_pc;
  logic         id_valid;
  logic         stall;
  logic         branch_taken;
  xlen_t        branch_target;
  reg_addr_t    rs1_addr;
  reg_addr_t    rs2_addr;
  xlen_t        rs1_data;
  xlen_t        rs2_data;
  logic         id_uses_rs1;
  logic         id_uses_rs2;

  // id/ex
  logic         ex_valid;
  xlen_t        ex_pc;
  xlen_t        ex_imm;
  alu_op_t      ex_alu_op;
  branch_kind_t ex_branch;
  logic         ex_use_imm;
  reg_addr_t    ex_rs1_addr;
  reg_addr_t    ex_rs2_addr;
  xlen_t        ex_rs1_data;
  xlen_t        ex_rs2_data;
  reg_addr_t    ex_rd_addr;
  logic         ex_rd_wr_ena;
  logic         ex_mem_rd;
  logic         ex_mem_wr;
  wb_src_t      ex_wb_src;
  xlen_t        rs1_value;
  xlen_t        rs2_value;

  // ex/mem
  logic         mem_valid;
  xlen_t        mem_pc;
  xlen_t        mem_alu_result;
  xlen_t        mem_store_data;
  reg_addr_t    mem_rd_addr;
  logic         mem_rd_wr_ena;
  logic         mem_mem_rd;
  logic         mem_mem_wr;
  wb_src_t      mem_wb_src;

  // mem/wb
  reg_addr_t    wb_rd_addr;
  logic         wb_rd_wr_ena;
  xlen_t        wb_data;

  fetch_stage fetch_stage_inst (
    .clock, .reset, .stall, .branch_taken, .branch_target,
    .inst_addr, .id_pc, .id_valid
  );

  decode_stage decode_stage_inst (
    .clock, .reset, .inst, .id_pc, .id_valid, .stall, .branch_taken,
    .rs1_data, .rs2_data, .rs1_addr, .rs2_addr, .id_uses_rs1, .id_uses_rs2,
    .ex_valid, .ex_pc, .ex_imm, .ex_alu_op, .ex_branch, .ex_use_imm,
    .ex_rs1_addr, .ex_rs2_addr, .ex_rs1_data, .ex_rs2_data,
    .ex_rd_addr, .ex_rd_wr_ena, .ex_mem_rd, .ex_mem_wr, .ex_wb_src
  );

  regfile regfile_inst (
    .clock, .reset, .rs1_addr, .rs2_addr,
    .wr_addr (wb_rd_addr),
    .wr_data (wb_data),
    .wr_ena  (wb_rd_wr_ena),
    .rs1_data, .rs2_data
  );

  hazard_unit hazard_unit_inst (
    .rs1_addr, .rs2_addr, .id_uses_rs1, .id_uses_rs2,
    .ex_mem_rd, .ex_rd_addr, .ex_valid,
    .ex_rs1_addr, .ex_rs2_addr, .ex_rs1_data, .ex_rs2_data,
    .mem_rd_addr, .mem_rd_wr_ena, .mem_alu_result,
    .wb_rd_addr, .wb_rd_wr_ena, .wb_data,
    .stall, .rs1_value, .rs2_value
  );

  execute_stage execute_stage_inst (
    .clock, .reset, .ex_valid, .ex_pc, .ex_imm, .ex_alu_op, .ex_branch,
    .ex_use_imm, .ex_rd_addr, .ex_rd_wr_ena, .ex_mem_rd, .ex_mem_wr, .ex_wb_src,
    .rs1_value, .rs2_value, .branch_taken, .branch_target,
    .mem_valid, .mem_pc, .mem_alu_result, .mem_store_data, .mem_rd_addr,
    .mem_rd_wr_ena, .mem_mem_rd, .mem_mem_wr, .mem_wb_src
  );

  memory_stage memory_stage_inst (
    .clock, .reset, .mem_valid, .mem_pc, .mem_alu_result, .mem_store_data,
    .mem_rd_addr, .mem_rd_wr_ena, .mem_mem_rd, .mem_mem_wr, .mem_wb_src,
    .data_rd_data, .data_addr, .data_wr_data, .data_wr_ena, .data_rd_ena,
    .wb_rd_addr, .wb_rd_wr_ena, .wb_data,
    .commit_valid, .commit_pc, .commit_reg_wr_ena, .commit_reg_addr, .commit_reg_data
  );

endmodule

// File: dv/tb_core.sv
/* core directed testbench */

`timescale 1ns/100ps

`include "core_settings.svh"

module tb_core import core_pkg::*; ();

  localparam int IMEM_DEPTH = 64;
  localparam int DATA_WORDS = 64;
  localparam xlen_t DATA_BASE = 64'h0;

  // program lengths for the timeout
  localparam int FWD_LEN = 10;
  localparam int LS_LEN = 10;
  localparam int BR_LEN = 14;
  localparam int X0_LEN = 4;
  localparam int CYCLE_LIMIT = 4 * (FWD_LEN + LS_LEN + BR_LEN + X0_LEN) + 100;

  logic      clock;
  logic      reset;
  xlen_t     inst_addr;
  inst_t     inst;
  xlen_t     data_addr;
  xlen_t     data_wr_data;
  logic      data_wr_ena;
  logic      data_rd_ena;
  xlen_t     data_rd_data;
  logic      commit_valid;
  xlen_t     commit_pc;
  logic      commit_reg_wr_ena;
  reg_addr_t commit_reg_addr;
  xlen_t     commit_reg_data;

  inst_t     imem [IMEM_DEPTH];
  xlen_t     dmem [DATA_WORDS];
  xlen_t     inst_index;
  inst_t     program_words [$];
  logic [31:0] rng_state;
  int        cycle_count = 0;

  // expected commits, stores and loads from the reference model
  xlen_t     exp_pc [$];
  logic      exp_wr [$];
  reg_addr_t exp_rd [$];
  xlen_t     exp_data [$];
  xlen_t     store_addr_q [$];
  xlen_t     store_data_q [$];
  xlen_t     load_addr_q [$];

  core_top core_top_inst (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("ERROR: run timed out after %0d cycles", cycle_count);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_word(input string name, input xlen_t got, input xlen_t expected);
    if (got !== expected) begin
      $display("FAILED time %0t: %s = %h, expected %h", $time, name, got, expected);
      abort_run();
    end
  endtask

  task automatic compare_reg_addr(input string name, input reg_addr_t got,
                                  input reg_addr_t expected);
    if (got !== expected) begin
      $display("FAILED time %0t: %s = x%0d, expected x%0d", $time, name, got, expected);
      abort_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("FAILED time %0t: %s = %b, expected %b", $time, name, got, expected);
      abort_run();
    end
  endtask

  // xorshift32
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [11:0] random_imm();
    logic [31:0] r;
    r = next_random();
    return r[11:0];
  endfunction

  // no-op whose immediate folds the whole address
  function automatic inst_t fill_inst(input xlen_t addr);
    logic [11:0] folded;
    folded = addr[11:0] ^ addr[23:12] ^ addr[35:24] ^ addr[47:36] ^ addr[59:48] ^
             {8'h00, addr[63:60]};
    return {folded, 5'd0, 3'b000, 5'd0, OP_IMM};
  endfunction

  function automatic xlen_t fill_data(input xlen_t addr);
    return {addr[31:0], ~addr[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
  endfunction

  function automatic logic data_in_window(input xlen_t addr);
    return addr[63:9] == DATA_BASE[63:9];
  endfunction

  function automatic inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic inst_t i_type(input opcode_t op, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t s_type(input reg_addr_t rs1, input reg_addr_t rs2,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], STORE};
  endfunction

  function automatic inst_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  // instruction memory read in the same cycle
  always_comb begin
    inst_index = (inst_addr - `RESET_PC) >> 2;
    if ((inst_addr >= `RESET_PC) && (inst_index < xlen_t'(IMEM_DEPTH))) begin
      inst = imem[inst_index[5:0]];
    end else begin
      inst = fill_inst(inst_addr);
    end
  end

  always_comb begin
    if (data_in_window(data_addr)) begin
      data_rd_data = dmem[data_addr[8:3]];
    end else begin
      data_rd_data = fill_data(data_addr);
    end
  end

  // data memory refills on reset
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < DATA_WORDS; i++) begin
        dmem[i] <= fill_data(DATA_BASE + xlen_t'(8 * i));
      end
    end else if (data_wr_ena && data_in_window(data_addr)) begin
      dmem[data_addr[8:3]] <= data_wr_data;
    end
  end

  // in-order ISA model of program_words
  task automatic predict_program();
    xlen_t      regs_model [32];
    xlen_t      mem_model [DATA_WORDS];
    xlen_t      pc;
    xlen_t      next_pc;
    xlen_t      a;
    xlen_t      b;
    xlen_t      result;
    xlen_t      addr;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    inst_t      word;
    reg_addr_t  rd;
    logic [2:0] f3;
    logic       writes;
    int         index;
    exp_pc.delete();
    exp_wr.delete();
    exp_rd.delete();
    exp_data.delete();
    store_addr_q.delete();
    store_data_q.delete();
    load_addr_q.delete();
    for (int i = 0; i < 32; i++) begin
      regs_model[i] = '0;
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      mem_model[i] = fill_data(DATA_BASE + xlen_t'(8 * i));
    end
    pc = `RESET_PC;
    for (int step = 0; step < 256; step++) begin
      index = int'((pc - `RESET_PC) >> 2);
      if ((pc < `RESET_PC) || (index >= program_words.size())) begin
        break;
      end
      word = program_words[index];
      rd = word[11:7];
      f3 = word[14:12];
      a = regs_model[word[19:15]];
      b = regs_model[word[24:20]];
      imm_i = {{52{word[31]}}, word[31:20]};
      imm_s = {{52{word[31]}}, word[31:25], word[11:7]};
      imm_b = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
      next_pc = pc + 64'd4;
      writes = 1'b0;
      result = '0;
      case (opcode_t'(word[6:0]))
        OP: begin
          writes = 1'b1;
          if (f3 == 3'b000) begin
            result = word[30] ? a - b : a + b;
          end else if (f3 == 3'b111) begin
            result = a & b;
          end else if (f3 == 3'b110) begin
            result = a | b;
          end else begin
            result = a ^ b;
          end
        end
        OP_IMM: begin
          writes = 1'b1;
          result = a + imm_i;
        end
        LOAD: begin
          writes = 1'b1;
          addr = a + imm_i;
          load_addr_q.push_back(addr);
          result = data_in_window(addr) ? mem_model[addr[8:3]] : fill_data(addr);
        end
        STORE: begin
          addr = a + imm_s;
          store_addr_q.push_back(addr);
          store_data_q.push_back(b);
          if (data_in_window(addr)) begin
            mem_model[addr[8:3]] = b;
          end
        end
        BRANCH: begin
          if ((f3 == 3'b000) ? (a == b) : (a != b)) begin
            next_pc = pc + imm_b;
          end
        end
        default: begin
          writes = 1'b0;
        end
      endcase
      exp_pc.push_back(pc);
      exp_wr.push_back(writes && (rd != 5'd0));
      exp_rd.push_back(rd);
      exp_data.push_back(result);
      if (writes && (rd != 5'd0)) begin
        regs_model[rd] = result;
      end
      pc = next_pc;
    end
  endtask

  // reset for 3 cycles while the program is loaded
  task automatic start_program();
    @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    @(negedge clock);
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      if (i < program_words.size()) begin
        imem[i] = program_words[i];
      end else begin
        imem[i] = fill_inst(`RESET_PC + xlen_t'(4 * i));
      end
    end
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  endtask

  task automatic check_commits();
    logic wr_expected;
    reg_addr_t rd_expected;
    xlen_t data_expected;
    while ((exp_pc.size() > 0) || (store_addr_q.size() > 0) || (load_addr_q.size() > 0)) begin
      @(negedge clock);
      if (data_wr_ena) begin
        if (store_addr_q.size() == 0) begin
          $display("ERROR: at %0t a store to %h was not expected", $time, data_addr);
          abort_run();
        end else begin
          compare_word("data_addr", data_addr, store_addr_q.pop_front());
          compare_word("data_wr_data", data_wr_data, store_data_q.pop_front());
        end
      end
      if (data_rd_ena) begin
        if (load_addr_q.size() == 0) begin
          $display("ERROR: at %0t a load from %h was not expected", $time, data_addr);
          abort_run();
        end else begin
          compare_word("data_addr", data_addr, load_addr_q.pop_front());
        end
      end
      if (commit_valid) begin
        if (exp_pc.size() == 0) begin
          $display("ERROR: at %0t pc %h committed after the program ended", $time, commit_pc);
          abort_run();
        end else begin
          compare_word("commit_pc", commit_pc, exp_pc.pop_front());
          wr_expected = exp_wr.pop_front();
          rd_expected = exp_rd.pop_front();
          data_expected = exp_data.pop_front();
          compare_bit("commit_reg_wr_ena", commit_reg_wr_ena, wr_expected);
          if (wr_expected) begin
            compare_reg_addr("commit_reg_addr", commit_reg_addr, rd_expected);
            compare_word("commit_reg_data", commit_reg_data, data_expected);
          end
        end
      end
    end
  endtask

  task automatic run_program();
    predict_program();
    start_program();
    check_commits();
  endtask

  task automatic test_reset();
    program_words.delete();
    start_program();
    @(negedge clock);
    compare_word("inst_addr", inst_addr, `RESET_PC);
    compare_bit("commit_valid", commit_valid, 1'b0);
    compare_bit("data_wr_ena", data_wr_ena, 1'b0);
    compare_bit("data_rd_ena", data_rd_ena, 1'b0);
  endtask

  // each result feeds the next through MEM and WB
  task automatic test_forwarding();
    program_words.delete();
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, random_imm()));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd2, 5'd1, random_imm()));
    program_words.push_back(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    program_words.push_back(r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
    program_words.push_back(r_type(7'h00, 3'b100, 5'd5, 5'd4, 5'd3));
    program_words.push_back(r_type(7'h00, 3'b111, 5'd6, 5'd5, 5'd4));
    program_words.push_back(r_type(7'h00, 3'b110, 5'd7, 5'd6, 5'd2));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd3, 5'd7, random_imm()));
    program_words.push_back(r_type(7'h00, 3'b000, 5'd8, 5'd3, 5'd3));
    program_words.push_back(r_type(7'h20, 3'b000, 5'd9, 5'd0, 5'd8));
    run_program();
  endtask

  task automatic test_load_store();
    program_words.delete();
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd10, 5'd0, 12'h040));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd11, 5'd0, random_imm()));
    program_words.push_back(s_type(5'd10, 5'd11, 12'd8));
    program_words.push_back(i_type(LOAD, 3'b011, 5'd12, 5'd10, 12'd8));
    // load-use on rs1
    program_words.push_back(r_type(7'h00, 3'b000, 5'd13, 5'd12, 5'd11));
    // never written so the fill pattern comes back
    program_words.push_back(i_type(LOAD, 3'b011, 5'd14, 5'd10, 12'd16));
    program_words.push_back(r_type(7'h00, 3'b100, 5'd15, 5'd14, 5'd13));
    program_words.push_back(s_type(5'd10, 5'd15, 12'd24));
    program_words.push_back(i_type(LOAD, 3'b011, 5'd16, 5'd10, 12'd24));
    // load-use on store data
    program_words.push_back(s_type(5'd10, 5'd16, 12'd32));
    run_program();
  endtask

  task automatic test_branches();
    program_words.delete();
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, random_imm()));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd2, 5'd1, 12'd0));
    program_words.push_back(b_type(3'b000, 5'd1, 5'd2, 13'd8));
    program_words.push_back(s_type(5'd0, 5'd1, 12'd0));
    program_words.push_back(b_type(3'b001, 5'd1, 5'd2, 13'd8));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd3, 5'd1, 12'd7));
    program_words.push_back(b_type(3'b001, 5'd3, 5'd1, 13'd12));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd4, 5'd0, 12'd1));
    program_words.push_back(s_type(5'd0, 5'd3, 12'd8));
    program_words.push_back(b_type(3'b000, 5'd3, 5'd1, 13'd8));
    program_words.push_back(r_type(7'h00, 3'b000, 5'd5, 5'd3, 5'd1));
    program_words.push_back(b_type(3'b000, 5'd5, 5'd5, 13'd8));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd6, 5'd0, 12'd1));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd7, 5'd5, 12'd3));
    run_program();
  endtask

  task automatic test_zero_register();
    program_words.delete();
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd2, 5'd0, random_imm()));
    program_words.push_back(i_type(OP_IMM, 3'b000, 5'd0, 5'd2, random_imm() | 12'h001));
    program_words.push_back(r_type(7'h00, 3'b000, 5'd1, 5'd0, 5'd2));
    program_words.push_back(r_type(7'h00, 3'b100, 5'd3, 5'd0, 5'd0));
    run_program();
  endtask

  initial begin
    rng_state = 32'h57f6_859d;
    reset = 1'b1;
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      imem[i] = fill_inst(`RESET_PC + xlen_t'(4 * i));
    end
    test_reset();
    test_forwarding();
    test_load_store();
    test_branches();
    test_zero_register();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: flist.f
+incdir+src
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/regfile.sv
src/hazard_unit.sv
src/execute_stage.sv
src/memory_stage.sv
src/core_top.sv
dv/tb_core.sv

// File: Makefile
# Verilator build and run for the five-stage core testbench

VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
SOURCES   := $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
